//--- Makefile
# Verilator build and run of the execute stage testbench

VERILATOR ?= verilator
TOP       ?= ex_stage_tb
FILELIST  ?= ex_stage.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, search the log for the pass message"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- ex_stage.f
+incdir+source
source/ex_pkg.sv
source/ex_alu.sv
source/ex_mult.sv
source/ex_result_sel.sv
source/ex_wb_reg.sv
source/ex_stage.sv
tb/ex_stage_tb.sv

//--- source/ex_alu.sv
////////////////////////////////////////
// Integer ALU, purely combinational
// Arithmetic, logic, shifts, set-less-than
// and branch compares in one cycle
////////////////////////////////////////

`timescale 1ns/100ps

`include "ex_defines.svh"

module ex_alu (
  input  ex_pkg::alu_op_e       operator_i,
  input  logic [`EX_XLEN-1:0]   operand_a_i,
  input  logic [`EX_XLEN-1:0]   operand_b_i,
  output logic [`EX_XLEN-1:0]   result_o,
  output logic                  comparison_result_o
);

  import ex_pkg::*;

  // Adder shared by add, sub and all less-than checks
  logic                    adder_sub;
  logic                    cmp_signed;
  logic [`EX_XLEN:0]       adder_a;
  logic [`EX_XLEN:0]       adder_b;
  logic [`EX_XLEN:0]       adder_sum;
  logic                    is_less;
  logic                    is_equal;

  // Shifter
  logic [`EX_SHAMT_W-1:0]  shamt;
  logic                    shift_left;
  logic                    shift_arith;
  logic [`EX_XLEN-1:0]     shift_in;
  logic [`EX_XLEN:0]       shift_ext;
  logic [`EX_XLEN-1:0]     shift_result;

  // Reverse bit order so one right shifter also serves left shifts
  function automatic logic [`EX_XLEN-1:0] bit_rev(input logic [`EX_XLEN-1:0] v);
    logic [`EX_XLEN-1:0] r;
    for (int i = 0; i < `EX_XLEN; i++) begin
      r[i] = v[`EX_XLEN-1-i];
    end
    return r;
  endfunction

  ////////////////////////////////////////
  // Adder and comparison flags
  ////////////////////////////////////////

  assign adder_sub  = operator_i inside {ALU_SUB, ALU_SLT, ALU_SLTU, ALU_LT,
                                         ALU_GE, ALU_LTU, ALU_GEU};
  assign cmp_signed = operator_i inside {ALU_SLT, ALU_LT, ALU_GE};

  // One extra bit, sign or zero, keeps the difference from overflowing
  assign adder_a   = {cmp_signed & operand_a_i[`EX_XLEN-1], operand_a_i};
  assign adder_b   = {cmp_signed & operand_b_i[`EX_XLEN-1], operand_b_i};
  assign adder_sum = adder_a + (adder_sub ? ~adder_b : adder_b)
                     + {{`EX_XLEN{1'b0}}, adder_sub};

  // Top bit of a - b is the less-than flag
  assign is_less  = adder_sum[`EX_XLEN];
  assign is_equal = (operand_a_i == operand_b_i);

  ////////////////////////////////////////
  // Barrel shifter
  ////////////////////////////////////////

  assign shamt       = operand_b_i[`EX_SHAMT_W-1:0];
  assign shift_left  = (operator_i == ALU_SLL);
  assign shift_arith = (operator_i == ALU_SRA);
  assign shift_in    = shift_left ? bit_rev(operand_a_i) : operand_a_i;
  // Fill bit is the sign only for SRA
  assign shift_ext   = $signed({shift_arith & shift_in[`EX_XLEN-1], shift_in}) >>> shamt;
  assign shift_result = shift_left ? bit_rev(shift_ext[`EX_XLEN-1:0])
                                   : shift_ext[`EX_XLEN-1:0];

  // Compare outcome, branch condition or set-less-than bit
  always_comb begin
    case (operator_i)
      ALU_EQ:                        comparison_result_o = is_equal;
      ALU_NE:                        comparison_result_o = ~is_equal;
      ALU_LT, ALU_LTU,
      ALU_SLT, ALU_SLTU:             comparison_result_o = is_less;
      ALU_GE, ALU_GEU:               comparison_result_o = ~is_less;
      default:                       comparison_result_o = 1'b0;
    endcase
  end

  // Result select
  always_comb begin
    case (operator_i)
      ALU_ADD, ALU_SUB:          result_o = adder_sum[`EX_XLEN-1:0];
      ALU_AND:                   result_o = operand_a_i & operand_b_i;
      ALU_OR:                    result_o = operand_a_i | operand_b_i;
      ALU_XOR:                   result_o = operand_a_i ^ operand_b_i;
      ALU_SLL, ALU_SRL, ALU_SRA: result_o = shift_result;
      // Set and compare opcodes return the flag zero-extended
      ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE,
      ALU_LT, ALU_GE, ALU_LTU, ALU_GEU:
        result_o = {{(`EX_XLEN-1){1'b0}}, comparison_result_o};
      default:                   result_o = '0;
    endcase
  end

endmodule

//--- source/ex_defines.svh
////////////////////////////////////////
// Width macros for the execute stage
// Include in any file that sizes data,
// register addresses or opcodes
////////////////////////////////////////

`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

// Data path width
`define EX_XLEN 32

// Register file address, includes the extra bit for FP registers
`define EX_RADDR_W 6

// Opcode widths for the ALU and the multiplier
`define EX_ALU_OP_W 4
`define EX_MULT_OP_W 2

// Shift amount, low bits of operand b
`define EX_SHAMT_W 5

`endif

//--- source/ex_mult.sv
////////////////////////////////////////
// Integer multiplier
// Low word in one cycle and high words
// in two while operands are held until
// ex_ready_i
////////////////////////////////////////

`timescale 1ns/100ps

`include "ex_defines.svh"

module ex_mult (
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  enable_i,
  input  ex_pkg::mult_op_e      operator_i,
  input  logic [`EX_XLEN-1:0]   op_a_i,
  input  logic [`EX_XLEN-1:0]   op_b_i,

  // Stage may advance and leave the FINISH state
  input  logic                  ex_ready_i,

  output logic [`EX_XLEN-1:0]   result_o,
  output logic                  ready_o,
  output logic                  multicycle_o
);

  import ex_pkg::*;

  logic                           a_signed;
  logic                           b_signed;
  logic                           is_high;
  logic signed [`EX_XLEN:0]       op_a_ext;
  logic signed [`EX_XLEN:0]       op_b_ext;
  logic signed [2*`EX_XLEN+1:0]   product;
  mult_state_e                    state_q;
  mult_state_e                    state_d;

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////

  // Operand signedness per opcode
  // HSU takes a signed and b unsigned
  assign a_signed = (operator_i == MUL_HSS) || (operator_i == MUL_HSU);
  assign b_signed = (operator_i == MUL_HSS);
  assign is_high  = (operator_i != MUL_LO);

  // 33 bit operands so one signed multiply covers all three cases
  assign op_a_ext = $signed({a_signed & op_a_i[`EX_XLEN-1], op_a_i});
  assign op_b_ext = $signed({b_signed & op_b_i[`EX_XLEN-1], op_b_i});
  assign product  = (2*`EX_XLEN+2)'(op_a_ext) * (2*`EX_XLEN+2)'(op_b_ext);

  // Low word does not depend on signedness
  assign result_o = is_high ? product[2*`EX_XLEN-1:`EX_XLEN] : product[`EX_XLEN-1:0];

  ////////////////////////////////////////
  // High product sequencer
  ////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    ready_o      = 1'b1;
    multicycle_o = 1'b0;

    case (state_q)
      MULT_IDLE: begin
        // High word costs one extra cycle
        if (enable_i && is_high) begin
          ready_o = 1'b0;
          state_d = MULT_FINISH;
        end
      end

      MULT_FINISH: begin
        // Result is valid until the stage moves on
        multicycle_o = 1'b1;
        if (ex_ready_i) begin
          state_d = MULT_IDLE;
        end
      end

      default: begin
        state_d = MULT_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MULT_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

//--- source/ex_pkg.sv
////////////////////////////////////////
// Shared types of the execute stage
// ALU and multiplier opcodes, plus the
// multiplier sequencer states
////////////////////////////////////////

`include "ex_defines.svh"

package ex_pkg;

  // ALU operations, the last six are branch compares
  typedef enum logic [`EX_ALU_OP_W-1:0] {
    ALU_ADD  = 4'h0,
    ALU_SUB  = 4'h1,
    ALU_AND  = 4'h2,
    ALU_OR   = 4'h3,
    ALU_XOR  = 4'h4,
    ALU_SLL  = 4'h5,
    ALU_SRL  = 4'h6,
    ALU_SRA  = 4'h7,
    ALU_SLT  = 4'h8,
    ALU_SLTU = 4'h9,
    ALU_EQ   = 4'ha,
    ALU_NE   = 4'hb,
    ALU_LT   = 4'hc,
    ALU_GE   = 4'hd,
    ALU_LTU  = 4'he,
    ALU_GEU  = 4'hf
  } alu_op_e;

  // Multiplier operations, low word or one of three high words
  typedef enum logic [`EX_MULT_OP_W-1:0] {
    MUL_LO  = 2'd0,
    MUL_HSS = 2'd1,
    MUL_HUU = 2'd2,
    MUL_HSU = 2'd3
  } mult_op_e;

  // Sequencer for the two-cycle high products
  typedef enum logic {
    MULT_IDLE   = 1'b0,
    MULT_FINISH = 1'b1
  } mult_state_e;

endpackage

//--- source/ex_result_sel.sv
////////////////////////////////////////
// ALU write port forwarding and stall
// Picks CSR, multiplier or ALU data and
// builds ex_ready and ex_valid
////////////////////////////////////////

`timescale 1ns/100ps

`include "ex_defines.svh"

module ex_result_sel (
  // Unit enables from ID
  input  logic                     alu_en_i,
  input  logic                     mult_en_i,
  input  logic                     csr_access_i,
  input  logic                     lsu_en_i,

  // ALU write port request from ID
  input  logic                     regfile_alu_we_i,
  input  logic [`EX_RADDR_W-1:0]   regfile_alu_waddr_i,

  // Unit results
  input  logic [`EX_XLEN-1:0]      alu_result_i,
  input  logic [`EX_XLEN-1:0]      mult_result_i,
  input  logic [`EX_XLEN-1:0]      csr_rdata_i,

  // Ready levels
  input  logic                     mult_ready_i,
  input  logic                     lsu_ready_ex_i,
  input  logic                     wb_ready_i,
  input  logic                     branch_in_ex_i,

  // Forward port to register file and ID
  output logic                     regfile_alu_we_fw_o,
  output logic [`EX_RADDR_W-1:0]   regfile_alu_waddr_fw_o,
  output logic [`EX_XLEN-1:0]      regfile_alu_wdata_fw_o,

  output logic                     ex_ready_o,
  output logic                     ex_valid_o
);

  logic units_ready;

  // Forward data, CSR first, then multiplier, then ALU
  always_comb begin
    regfile_alu_wdata_fw_o = '0;
    if (csr_access_i) begin
      regfile_alu_wdata_fw_o = csr_rdata_i;
    end else if (mult_en_i) begin
      regfile_alu_wdata_fw_o = mult_result_i;
    end else if (alu_en_i) begin
      regfile_alu_wdata_fw_o = alu_result_i;
    end
  end

  // Enable and address come straight from ID
  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;

  ////////////////////////////////////////
  // Stall control
  ////////////////////////////////////////

  // ALU is always ready and does not appear here
  assign units_ready = mult_ready_i & lsu_ready_ex_i & wb_ready_i;

  // Branches resolve here and never need WB
  assign ex_ready_o = units_ready | branch_in_ex_i;
  // Valid flows forward only, independent of ex_ready
  assign ex_valid_o = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) & units_ready;

endmodule

//--- source/ex_stage.sv
////////////////////////////////////////
// Execute stage top level
// ALU and multiplier side by side, then
// result select and the EX/WB register
////////////////////////////////////////

`timescale 1ns/100ps

`include "ex_defines.svh"

module ex_stage (
  input  logic                     clk,
  input  logic                     rst_n,

  // ALU inputs from ID
  input  logic                     alu_en_i,
  input  ex_pkg::alu_op_e          alu_operator_i,
  input  logic [`EX_XLEN-1:0]      alu_operand_a_i,
  input  logic [`EX_XLEN-1:0]      alu_operand_b_i,
  input  logic [`EX_XLEN-1:0]      alu_operand_c_i,

  // Multiplier inputs from ID
  input  logic                     mult_en_i,
  input  ex_pkg::mult_op_e         mult_operator_i,
  input  logic [`EX_XLEN-1:0]      mult_operand_a_i,
  input  logic [`EX_XLEN-1:0]      mult_operand_b_i,

  // CSR and LSU
  input  logic                     csr_access_i,
  input  logic [`EX_XLEN-1:0]      csr_rdata_i,
  input  logic                     lsu_en_i,
  input  logic [`EX_XLEN-1:0]      lsu_rdata_i,
  input  logic                     lsu_ready_ex_i,

  input  logic                     branch_in_ex_i,

  // Write port requests from ID
  input  logic                     regfile_alu_we_i,
  input  logic [`EX_RADDR_W-1:0]   regfile_alu_waddr_i,
  input  logic                     regfile_we_i,
  input  logic [`EX_RADDR_W-1:0]   regfile_waddr_i,

  input  logic                     wb_ready_i,

  // Forward port
  output logic                     regfile_alu_we_fw_o,
  output logic [`EX_RADDR_W-1:0]   regfile_alu_waddr_fw_o,
  output logic [`EX_XLEN-1:0]      regfile_alu_wdata_fw_o,

  // Load write-back port
  output logic                     regfile_we_wb_o,
  output logic [`EX_RADDR_W-1:0]   regfile_waddr_wb_o,
  output logic [`EX_XLEN-1:0]      regfile_wdata_wb_o,

  // To IF and the controller
  output logic [`EX_XLEN-1:0]      jump_target_o,
  output logic                     branch_decision_o,
  output logic                     mult_multicycle_o,

  output logic                     ex_ready_o,
  output logic                     ex_valid_o
);

  logic [`EX_XLEN-1:0] alu_result;
  logic                alu_cmp_result;
  logic [`EX_XLEN-1:0] mult_result;
  logic                mult_ready;

  // Branch target computed in ID, decision from the ALU compare
  assign jump_target_o     = alu_operand_c_i;
  assign branch_decision_o = alu_cmp_result;

  ////////////////////////////////////////
  // Units
  ////////////////////////////////////////

  ex_alu alu0 (
    .operator_i          (alu_operator_i),
    .operand_a_i         (alu_operand_a_i),
    .operand_b_i         (alu_operand_b_i),
    .result_o            (alu_result),
    .comparison_result_o (alu_cmp_result)
  );

  ex_mult mult0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (mult_en_i),
    .operator_i   (mult_operator_i),
    .op_a_i       (mult_operand_a_i),
    .op_b_i       (mult_operand_b_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .ready_o      (mult_ready),
    .multicycle_o (mult_multicycle_o)
  );

  ////////////////////////////////////////
  // Result select, stall, write-back
  ////////////////////////////////////////

  ex_result_sel sel0 (
    .alu_en_i               (alu_en_i),
    .mult_en_i              (mult_en_i),
    .csr_access_i           (csr_access_i),
    .lsu_en_i               (lsu_en_i),
    .regfile_alu_we_i       (regfile_alu_we_i),
    .regfile_alu_waddr_i    (regfile_alu_waddr_i),
    .alu_result_i           (alu_result),
    .mult_result_i          (mult_result),
    .csr_rdata_i            (csr_rdata_i),
    .mult_ready_i           (mult_ready),
    .lsu_ready_ex_i         (lsu_ready_ex_i),
    .wb_ready_i             (wb_ready_i),
    .branch_in_ex_i         (branch_in_ex_i),
    .regfile_alu_we_fw_o    (regfile_alu_we_fw_o),
    .regfile_alu_waddr_fw_o (regfile_alu_waddr_fw_o),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw_o),
    .ex_ready_o             (ex_ready_o),
    .ex_valid_o             (ex_valid_o)
  );

  ex_wb_reg wb0 (
    .clk                (clk),
    .rst_n              (rst_n),
    .ex_valid_i         (ex_valid_o),
    .wb_ready_i         (wb_ready_i),
    .regfile_we_i       (regfile_we_i),
    .regfile_waddr_i    (regfile_waddr_i),
    .lsu_rdata_i        (lsu_rdata_i),
    .regfile_we_wb_o    (regfile_we_wb_o),
    .regfile_waddr_wb_o (regfile_waddr_wb_o),
    .regfile_wdata_wb_o (regfile_wdata_wb_o)
  );

endmodule

//--- source/ex_wb_reg.sv
////////////////////////////////////////
// EX/WB pipeline register
// Carries load write-back address and
// enable, load data passes through
////////////////////////////////////////

`timescale 1ns/100ps

`include "ex_defines.svh"

module ex_wb_reg (
  input  logic                     clk,
  input  logic                     rst_n,

  input  logic                     ex_valid_i,
  input  logic                     wb_ready_i,

  // Load destination from ID
  input  logic                     regfile_we_i,
  input  logic [`EX_RADDR_W-1:0]   regfile_waddr_i,
  input  logic [`EX_XLEN-1:0]      lsu_rdata_i,

  output logic                     regfile_we_wb_o,
  output logic [`EX_RADDR_W-1:0]   regfile_waddr_wb_o,
  output logic [`EX_XLEN-1:0]      regfile_wdata_wb_o
);

  // Write enable, valid implies WB was ready
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      regfile_we_wb_o <= 1'b0;
    end else if (ex_valid_i) begin
      regfile_we_wb_o <= regfile_we_i;
    end else if (wb_ready_i) begin
      // Nothing new arrives, flush the old entry out
      regfile_we_wb_o <= 1'b0;
    end
  end

  // Address, only taken for a real write
  always_ff @(posedge clk) begin
    if (ex_valid_i && regfile_we_i) begin
      regfile_waddr_wb_o <= regfile_waddr_i;
    end
  end

  assign regfile_wdata_wb_o = lsu_rdata_i;

endmodule

//--- tb/ex_stage_tb.sv
////////////////////////////////////////
// Testbench for the execute stage
// LFSR stimulus and reference models
// Concurrent assertions check every edge
////////////////////////////////////////

`timescale 1ns/100ps

`include "ex_defines.svh"

module ex_stage_tb;

  import ex_pkg::*;

  localparam int RESET_CYCLES = 16;
  localparam int N_ALU  = 200;
  localparam int N_CMP  = 48;
  localparam int N_MUL  = 32;
  localparam int N_PRIO = 32;
  localparam int N_WB   = 84;
  localparam int N_BR   = 24;
  // Four times the nominal length with three cycles per high product
  localparam int CYCLE_LIMIT = 4 * (RESET_CYCLES + N_ALU + N_CMP + 3 * N_MUL
                                    + N_PRIO + N_WB + N_BR);

  logic clk;
  logic rst_n;
  logic alu_en_i;
  alu_op_e alu_operator_i;
  logic [`EX_XLEN-1:0] alu_operand_a_i;
  logic [`EX_XLEN-1:0] alu_operand_b_i;
  logic [`EX_XLEN-1:0] alu_operand_c_i;
  logic mult_en_i;
  mult_op_e mult_operator_i;
  logic [`EX_XLEN-1:0] mult_operand_a_i;
  logic [`EX_XLEN-1:0] mult_operand_b_i;
  logic csr_access_i;
  logic [`EX_XLEN-1:0] csr_rdata_i;
  logic lsu_en_i;
  logic [`EX_XLEN-1:0] lsu_rdata_i;
  logic lsu_ready_ex_i;
  logic branch_in_ex_i;
  logic regfile_alu_we_i;
  logic [`EX_RADDR_W-1:0] regfile_alu_waddr_i;
  logic regfile_we_i;
  logic [`EX_RADDR_W-1:0] regfile_waddr_i;
  logic wb_ready_i;
  logic regfile_alu_we_fw_o;
  logic [`EX_RADDR_W-1:0] regfile_alu_waddr_fw_o;
  logic [`EX_XLEN-1:0] regfile_alu_wdata_fw_o;
  logic regfile_we_wb_o;
  logic [`EX_RADDR_W-1:0] regfile_waddr_wb_o;
  logic [`EX_XLEN-1:0] regfile_wdata_wb_o;
  logic [`EX_XLEN-1:0] jump_target_o;
  logic branch_decision_o;
  logic mult_multicycle_o;
  logic ex_ready_o;
  logic ex_valid_o;

  // Reference state and last-edge copies
  logic mdl_finish;
  logic hi_start;
  logic exp_ready;
  logic exp_valid;
  logic exp_cmp;
  logic [`EX_XLEN-1:0] exp_fw;
  logic prev_hi_start;
  logic prev_valid;
  logic prev_wb_ready;
  logic prev_we_i;
  logic [`EX_RADDR_W-1:0] prev_waddr_i;
  logic prev_we_wb;
  logic [`EX_RADDR_W-1:0] prev_waddr_wb;

  logic [15:0] lfsr_state = 16'd19126;
  int errors = 0;
  int tests_run = 0;
  int tests_failed = 0;

  ex_stage dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per bit
  task automatic get_rand(input int nbits, output logic [`EX_XLEN-1:0] v);
    v = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[`EX_XLEN-2:0], lfsr_state[0]};
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic idle_inputs();
    alu_en_i = 1'b0;
    alu_operator_i = ALU_ADD;
    alu_operand_a_i = '0;
    alu_operand_b_i = '0;
    alu_operand_c_i = '0;
    mult_en_i = 1'b0;
    mult_operator_i = MUL_LO;
    mult_operand_a_i = '0;
    mult_operand_b_i = '0;
    csr_access_i = 1'b0;
    csr_rdata_i = '0;
    lsu_en_i = 1'b0;
    lsu_rdata_i = '0;
    lsu_ready_ex_i = 1'b1;
    branch_in_ex_i = 1'b0;
    regfile_alu_we_i = 1'b0;
    regfile_alu_waddr_i = '0;
    regfile_we_i = 1'b0;
    regfile_waddr_i = '0;
    wb_ready_i = 1'b1;
  endtask

  task automatic value_error(input string sig, input logic [`EX_XLEN-1:0] exp_v,
                             input logic [`EX_XLEN-1:0] act_v);
    $display("** Error at %0d ns: %s expected %h, got %h", $time, sig, exp_v, act_v);
    errors++;
  endtask

  task automatic plain_error(input string msg);
    $display("Error at %0d ns: %s", $time, msg);
    errors++;
  endtask

  ////////////////////////////////////////
  // Reference models
  ////////////////////////////////////////

  function automatic logic cmp_model(input alu_op_e op, input logic [`EX_XLEN-1:0] a,
                                     input logic [`EX_XLEN-1:0] b);
    case (op)
      ALU_EQ:            return a == b;
      ALU_NE:            return a != b;
      ALU_LT, ALU_SLT:   return $signed(a) < $signed(b);
      ALU_GE:            return $signed(a) >= $signed(b);
      ALU_LTU, ALU_SLTU: return a < b;
      ALU_GEU:           return a >= b;
      default:           return 1'b0;
    endcase
  endfunction

  function automatic logic [`EX_XLEN-1:0] alu_model(input alu_op_e op,
      input logic [`EX_XLEN-1:0] a, input logic [`EX_XLEN-1:0] b);
    case (op)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      ALU_SLL: return a << b[4:0];
      ALU_SRL: return a >> b[4:0];
      ALU_SRA: return $signed(a) >>> b[4:0];
      default: return {{(`EX_XLEN-1){1'b0}}, cmp_model(op, a, b)};
    endcase
  endfunction

  // Full 64 bit product of the extended operands
  function automatic logic [`EX_XLEN-1:0] mult_model(input mult_op_e op,
      input logic [`EX_XLEN-1:0] a, input logic [`EX_XLEN-1:0] b);
    logic [63:0] a64;
    logic [63:0] b64;
    logic [63:0] p;
    a64 = (op == MUL_HSS || op == MUL_HSU) ? {{32{a[31]}}, a} : {32'b0, a};
    b64 = (op == MUL_HSS) ? {{32{b[31]}}, b} : {32'b0, b};
    p = a64 * b64;
    return (op == MUL_LO) ? p[31:0] : p[63:32];
  endfunction

  always_comb begin
    // High product in idle costs the stall cycle
    hi_start  = mult_en_i && (mult_operator_i != MUL_LO) && !mdl_finish;
    exp_ready = (!hi_start && lsu_ready_ex_i && wb_ready_i) || branch_in_ex_i;
    exp_valid = (alu_en_i || mult_en_i || csr_access_i || lsu_en_i)
                && !hi_start && lsu_ready_ex_i && wb_ready_i;
    exp_cmp   = cmp_model(alu_operator_i, alu_operand_a_i, alu_operand_b_i);
    if (csr_access_i) begin
      exp_fw = csr_rdata_i;
    end else if (mult_en_i) begin
      exp_fw = mult_model(mult_operator_i, mult_operand_a_i, mult_operand_b_i);
    end else if (alu_en_i) begin
      exp_fw = alu_model(alu_operator_i, alu_operand_a_i, alu_operand_b_i);
    end else begin
      exp_fw = '0;
    end
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mdl_finish    <= 1'b0;
      prev_hi_start <= 1'b0;
      prev_valid    <= 1'b0;
      prev_wb_ready <= 1'b1;
      prev_we_i     <= 1'b0;
      prev_waddr_i  <= '0;
      prev_we_wb    <= 1'b0;
      prev_waddr_wb <= '0;
    end else begin
      if (hi_start) begin
        mdl_finish <= 1'b1;
      end else if (mdl_finish && exp_ready) begin
        mdl_finish <= 1'b0;
      end
      prev_hi_start <= hi_start && lsu_ready_ex_i && wb_ready_i && !branch_in_ex_i;
      prev_valid    <= exp_valid;
      prev_wb_ready <= wb_ready_i;
      prev_we_i     <= regfile_we_i;
      prev_waddr_i  <= regfile_waddr_i;
      prev_we_wb    <= regfile_we_wb_o;
      prev_waddr_wb <= regfile_waddr_wb_o;
    end
  end

  ////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////

  a_fw_data: assert property (@(posedge clk) disable iff (!rst_n)
      regfile_alu_wdata_fw_o == exp_fw)
    else value_error("regfile_alu_wdata_fw_o", $sampled(exp_fw),
                     $sampled(regfile_alu_wdata_fw_o));
  a_fw_we: assert property (@(posedge clk) disable iff (!rst_n)
      regfile_alu_we_fw_o == regfile_alu_we_i)
    else value_error("regfile_alu_we_fw_o", 32'($sampled(regfile_alu_we_i)),
                     32'($sampled(regfile_alu_we_fw_o)));
  a_fw_waddr: assert property (@(posedge clk) disable iff (!rst_n)
      regfile_alu_waddr_fw_o == regfile_alu_waddr_i)
    else value_error("regfile_alu_waddr_fw_o", 32'($sampled(regfile_alu_waddr_i)),
                     32'($sampled(regfile_alu_waddr_fw_o)));
  a_branch: assert property (@(posedge clk) disable iff (!rst_n)
      branch_decision_o == exp_cmp)
    else value_error("branch_decision_o", 32'($sampled(exp_cmp)),
                     32'($sampled(branch_decision_o)));
  a_jump: assert property (@(posedge clk) disable iff (!rst_n)
      jump_target_o == alu_operand_c_i)
    else value_error("jump_target_o", $sampled(alu_operand_c_i), $sampled(jump_target_o));
  a_ready: assert property (@(posedge clk) disable iff (!rst_n) ex_ready_o == exp_ready)
    else value_error("ex_ready_o", 32'($sampled(exp_ready)), 32'($sampled(ex_ready_o)));
  a_valid: assert property (@(posedge clk) disable iff (!rst_n) ex_valid_o == exp_valid)
    else value_error("ex_valid_o", 32'($sampled(exp_valid)), 32'($sampled(ex_valid_o)));
  a_multicycle: assert property (@(posedge clk) disable iff (!rst_n)
      mult_multicycle_o == mdl_finish)
    else value_error("mult_multicycle_o", 32'($sampled(mdl_finish)),
                     32'($sampled(mult_multicycle_o)));
  // Stall lasts one cycle and the result cycle is ready
  a_hi_finish: assert property (@(posedge clk) disable iff (!rst_n)
      prev_hi_start && lsu_ready_ex_i && wb_ready_i |-> mult_multicycle_o && ex_ready_o)
    else plain_error("high product result cycle lacks ex_ready_o or mult_multicycle_o");
  a_wb_we: assert property (@(posedge clk) disable iff (!rst_n)
      prev_valid |-> regfile_we_wb_o == prev_we_i)
    else value_error("regfile_we_wb_o", 32'($sampled(prev_we_i)),
                     32'($sampled(regfile_we_wb_o)));
  a_wb_waddr: assert property (@(posedge clk) disable iff (!rst_n)
      prev_valid && prev_we_i |-> regfile_waddr_wb_o == prev_waddr_i)
    else value_error("regfile_waddr_wb_o", 32'($sampled(prev_waddr_i)),
                     32'($sampled(regfile_waddr_wb_o)));
  a_wb_flush: assert property (@(posedge clk) disable iff (!rst_n)
      !prev_valid && prev_wb_ready |-> !regfile_we_wb_o)
    else value_error("regfile_we_wb_o", 32'd0, 32'($sampled(regfile_we_wb_o)));
  a_wb_hold_we: assert property (@(posedge clk) disable iff (!rst_n)
      !prev_wb_ready |-> regfile_we_wb_o === prev_we_wb)
    else value_error("regfile_we_wb_o", 32'($sampled(prev_we_wb)),
                     32'($sampled(regfile_we_wb_o)));
  a_wb_hold_waddr: assert property (@(posedge clk) disable iff (!rst_n)
      !prev_wb_ready |-> regfile_waddr_wb_o === prev_waddr_wb)
    else value_error("regfile_waddr_wb_o", 32'($sampled(prev_waddr_wb)),
                     32'($sampled(regfile_waddr_wb_o)));
  a_wdata: assert property (@(posedge clk) disable iff (!rst_n)
      regfile_wdata_wb_o == lsu_rdata_i)
    else value_error("regfile_wdata_wb_o", $sampled(lsu_rdata_i),
                     $sampled(regfile_wdata_wb_o));
  a_branch_ready: assert property (@(posedge clk) disable iff (!rst_n)
      branch_in_ex_i |-> ex_ready_o)
    else plain_error("ex_ready_o dropped while a branch sits in EX");

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic end_test(input string name, input int errs_before);
    next_cycle();
    idle_inputs();
    repeat (2) next_cycle();
    tests_run++;
    if (errors != errs_before) begin
      tests_failed++;
    end
    $display("test %0d %s: %s", tests_run, name, (errors == errs_before) ? "ok" : "failed");
  endtask

  task automatic run_alu_test();
    logic [`EX_XLEN-1:0] r;
    for (int i = 0; i < N_ALU; i++) begin
      next_cycle();
      get_rand(4, r);
      alu_operator_i = alu_op_e'(r[3:0]);
      get_rand(32, alu_operand_a_i);
      get_rand(32, alu_operand_b_i);
      get_rand(7, r);
      regfile_alu_we_i = r[6];
      regfile_alu_waddr_i = r[5:0];
      alu_en_i = 1'b1;
    end
  endtask

  task automatic run_cmp_test();
    logic [`EX_XLEN-1:0] r;
    alu_op_e cmp_ops [6] = '{ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU};
    for (int i = 0; i < N_CMP; i++) begin
      next_cycle();
      alu_en_i = 1'b1;
      alu_operator_i = cmp_ops[i % 6];
      get_rand(32, alu_operand_a_i);
      get_rand(32, alu_operand_b_i);
      get_rand(32, alu_operand_c_i);
      get_rand(1, r);
      // Equal operands half the time so EQ and GE take both outcomes
      if (r[0]) begin
        alu_operand_b_i = alu_operand_a_i;
      end
    end
  endtask

  task automatic run_mult_test();
    logic [`EX_XLEN-1:0] r;
    for (int i = 0; i < N_MUL; i++) begin
      next_cycle();
      get_rand(2, r);
      mult_operator_i = mult_op_e'(r[1:0]);
      get_rand(32, mult_operand_a_i);
      get_rand(32, mult_operand_b_i);
      mult_en_i = 1'b1;
      // Operands held until the stage accepts them
      @(negedge clk);
      while (!ex_ready_o) begin
        @(negedge clk);
      end
    end
  endtask

  task automatic run_prio_test();
    logic [`EX_XLEN-1:0] r;
    for (int i = 0; i < N_PRIO; i++) begin
      next_cycle();
      get_rand(14, r);
      csr_access_i = r[0];
      mult_en_i = r[1];
      alu_en_i = r[2];
      alu_operator_i = alu_op_e'(r[6:3]);
      regfile_alu_we_i = r[7];
      regfile_alu_waddr_i = r[13:8];
      mult_operator_i = MUL_LO;
      get_rand(32, csr_rdata_i);
      get_rand(32, alu_operand_a_i);
      get_rand(32, alu_operand_b_i);
      get_rand(32, mult_operand_a_i);
      get_rand(32, mult_operand_b_i);
    end
  endtask

  task automatic run_wb_test();
    logic [`EX_XLEN-1:0] r;
    for (int i = 0; i < N_WB; i++) begin
      next_cycle();
      get_rand(10, r);
      lsu_en_i = r[0];
      regfile_we_i = r[1];
      // WB ready three times in four
      wb_ready_i = r[2] | r[3];
      regfile_waddr_i = r[9:4];
      get_rand(32, lsu_rdata_i);
    end
  endtask

  task automatic run_branch_test();
    logic [`EX_XLEN-1:0] r;
    for (int i = 0; i < N_BR; i++) begin
      next_cycle();
      get_rand(2, r);
      branch_in_ex_i = 1'b1;
      lsu_en_i = 1'b1;
      lsu_ready_ex_i = r[0];
      wb_ready_i = r[1];
    end
  endtask

  initial begin
    int errs;
    idle_inputs();
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst_n = 1'b1;
    errs = errors;
    run_alu_test();
    end_test("alu random ops", errs);
    errs = errors;
    run_cmp_test();
    end_test("branch compares", errs);
    errs = errors;
    run_mult_test();
    end_test("multiplier", errs);
    errs = errors;
    run_prio_test();
    end_test("forward priority", errs);
    errs = errors;
    run_wb_test();
    end_test("write-back register", errs);
    errs = errors;
    run_branch_test();
    end_test("branch bypass", errs);
    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule
